// File: source/adc_defs.svh
/*
 * LTC2308 sweep controller tunables
 * Timing, channel count and word sizes shared by the RTL and testbench
 */

`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// clock cycles in each half period of SCLK
`define ADC_SCLK_HALF 4

// clocks with chip-select high between frames, which is the CONVST pulse on
// this part; 40 keeps simulation short, hardware at 50 MHz wants 80 (1.6 us)
`define ADC_CONVERSION_CYCLES 40

// channels visited in one sweep, any value from 1 to 8
`define ADC_NUM_CHANNELS 8

// SCLK periods in one SPI frame
`define ADC_FRAME_BITS 12

// width of one conversion result
`define ADC_SAMPLE_BITS 12

`endif

// File: source/adcPkg.sv
/*
 * Types for the LTC2308 sweep controller
 * Samples, channel numbers, the command word, tagged results and the FSM states
 */

`include "adc_defs.svh"

package adcPkg;

        // one conversion value as returned on dout
        typedef logic [`ADC_SAMPLE_BITS-1:0] sample_t;

        // ADC input channel number
        typedef logic [2:0] channel_t;

        // command bits, first field goes out first on din
        typedef struct packed {
                logic       singleEnded;
                logic       oddSign;
                logic [1:0] select;
                logic       unipolar;
                logic       sleep;
        } ltcCommand_t;

        // a returned word tagged with the channel it belongs to
        typedef struct packed {
                logic     valid;
                channel_t channel;
                sample_t  value;
        } conversionResult_t;

        // all eight readings, index is the channel number
        typedef sample_t [7:0] readingArray_t;

        typedef enum logic [2:0] {
                idle,
                prime,
                primeGap,
                convert,
                convertGap,
                finished
        } sweepState_t;

endpackage

// File: source/sclkGenerator.sv
/*
 * SCLK generator for the LTC2308 SPI frame
 * Divides the system clock into SCLK, gives edge strobes and marks the frame end
 */

`timescale 1ns/1ns

`include "adc_defs.svh"

module sclkGenerator (
        input  logic clock,
        input  logic reset,
        input  logic frameActive,
        output logic sclk,
        output logic risingEdge,
        output logic fallingEdge,
        output logic frameEnd
);

        typedef logic [$clog2(`ADC_SCLK_HALF + 1)-1:0] halfCount_t;
        typedef logic [$clog2(`ADC_FRAME_BITS + 1)-1:0] bitCount_t;

        halfCount_t halfCount;
        bitCount_t  bitCount;
        logic       halfDone;

        assign halfDone = (halfCount == '0);

        // strobes fire in the cycle before SCLK actually changes, so the
        // shifters act on the same clock edge that moves the pin
        assign risingEdge  = frameActive && halfDone && !sclk;
        assign fallingEdge = frameActive && halfDone && sclk;

        assign frameEnd = fallingEdge && (bitCount == bitCount_t'(`ADC_FRAME_BITS - 1));

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        halfCount <= halfCount_t'(`ADC_SCLK_HALF - 1);
                        sclk      <= 1'b0;
                        bitCount  <= '0;
                end else if (!frameActive) begin
                        // SCLK parks low and the divider restarts with each frame
                        halfCount <= halfCount_t'(`ADC_SCLK_HALF - 1);
                        sclk      <= 1'b0;
                        bitCount  <= '0;
                end else if (halfDone) begin
                        halfCount <= halfCount_t'(`ADC_SCLK_HALF - 1);
                        sclk      <= !sclk;
                        if (frameEnd) begin
                                bitCount <= '0;
                        end else if (fallingEdge) begin
                                bitCount <= bitCount + 1'b1;
                        end
                end else begin
                        halfCount <= halfCount - 1'b1;
                end
        end

endmodule

// File: source/spiFrameShifter.sv
/*
 * SPI data path for one LTC2308 frame
 * Sends the six-bit command on din and collects the twelve result bits from dout
 */

`timescale 1ns/1ns

`include "adc_defs.svh"

module spiFrameShifter (
        input  logic                 clock,
        input  logic                 reset,
        input  logic                 loadCommand,
        input  adcPkg::ltcCommand_t  command,
        input  logic                 risingEdge,
        input  logic                 fallingEdge,
        input  logic                 frameEnd,
        input  logic                 dout,
        output logic                 din,
        output adcPkg::sample_t      word,
        output logic                 wordReady
);

        logic [`ADC_FRAME_BITS-1:0]  outShift;
        logic [`ADC_SAMPLE_BITS-1:0] inShift;

        // the command is padded with zeros so din rests low once it is out
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        outShift <= '0;
                end else if (loadCommand) begin
                        outShift <= {command,
                                {(`ADC_FRAME_BITS - $bits(adcPkg::ltcCommand_t)){1'b0}}};
                end else if (fallingEdge) begin
                        outShift <= {outShift[`ADC_FRAME_BITS-2:0], 1'b0};
                end
        end

        // MSB is on the pin from the moment the frame opens
        assign din = outShift[`ADC_FRAME_BITS-1];

        // dout was set up by the ADC half a period earlier, so it is stable here
        always_ff @(posedge clock) begin
                if (risingEdge) begin
                        inShift <= {inShift[`ADC_SAMPLE_BITS-2:0], dout};
                end
        end

        // all twelve bits have been sampled by the last falling edge
        assign word      = inShift;
        assign wordReady = frameEnd;

endmodule

// File: source/sweepController.sv
/*
 * Sweep sequencer for the LTC2308
 * Runs the priming frame, one frame per channel and the conversion gaps, then
 * holds done for as long as go stays high
 */

`timescale 1ns/1ns

`include "adc_defs.svh"

module sweepController (
        input  logic                       clock,
        input  logic                       reset,
        input  logic                       go,
        input  logic                       frameEnd,
        input  adcPkg::sample_t            word,
        output logic                       frameActive,
        output logic                       loadCommand,
        output adcPkg::ltcCommand_t        command,
        output adcPkg::conversionResult_t  result,
        output logic                       done
);

        typedef logic [$clog2(`ADC_CONVERSION_CYCLES + 1)-1:0] gapCount_t;

        adcPkg::sweepState_t state;
        adcPkg::channel_t    resultChannel;
        adcPkg::channel_t    commandChannel;
        adcPkg::channel_t    lastChannel;
        adcPkg::channel_t    nextCommandChannel;
        gapCount_t           gapCount;
        logic                gapOver;

        assign lastChannel = adcPkg::channel_t'(`ADC_NUM_CHANNELS - 1);
        assign gapOver     = (gapCount == '0);

        // channel numbers wrap so the final frame asks for channel 0 again
        assign nextCommandChannel = (commandChannel == lastChannel) ? '0 : commandChannel + 1'b1;

        assign frameActive = (state == adcPkg::prime) || (state == adcPkg::convert);
        assign done        = (state == adcPkg::finished);

        // the command is loaded in the last idle or gap cycle, just before the frame
        assign loadCommand = ((state == adcPkg::idle) && go) ||
                             ((state == adcPkg::primeGap) && gapOver) ||
                             ((state == adcPkg::convertGap) && gapOver &&
                              (resultChannel != lastChannel));

        always_comb begin
                command.singleEnded = 1'b1;
                command.oddSign     = commandChannel[0];
                command.select      = commandChannel[2:1];
                command.unipolar    = 1'b1;
                command.sleep       = 1'b0;
        end

        // the priming frame never produces a result, its data is stale
        always_comb begin
                result.valid   = (state == adcPkg::convert) && frameEnd;
                result.channel = resultChannel;
                result.value   = word;
        end

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        state          <= adcPkg::idle;
                        resultChannel  <= '0;
                        commandChannel <= '0;
                        gapCount       <= '0;
                end else begin
                        if (loadCommand) begin
                                commandChannel <= nextCommandChannel;
                        end
                        case (state)
                                adcPkg::idle: begin
                                        if (go) begin
                                                state <= adcPkg::prime;
                                        end
                                end
                                adcPkg::prime: begin
                                        if (frameEnd) begin
                                                state    <= adcPkg::primeGap;
                                                gapCount <= gapCount_t'(`ADC_CONVERSION_CYCLES - 1);
                                        end
                                end
                                adcPkg::primeGap: begin
                                        if (gapOver) begin
                                                state <= adcPkg::convert;
                                        end else begin
                                                gapCount <= gapCount - 1'b1;
                                        end
                                end
                                adcPkg::convert: begin
                                        if (frameEnd) begin
                                                state    <= adcPkg::convertGap;
                                                gapCount <= gapCount_t'(`ADC_CONVERSION_CYCLES - 1);
                                        end
                                end
                                adcPkg::convertGap: begin
                                        if (!gapOver) begin
                                                gapCount <= gapCount - 1'b1;
                                        end else if (resultChannel == lastChannel) begin
                                                state <= adcPkg::finished;
                                        end else begin
                                                resultChannel <= resultChannel + 1'b1;
                                                state         <= adcPkg::convert;
                                        end
                                end
                                adcPkg::finished: begin
                                        // get ready for the next sweep while done is shown
                                        resultChannel  <= '0;
                                        commandChannel <= '0;
                                        if (!go) begin
                                                state <= adcPkg::idle;
                                        end
                                end
                                default: begin
                                        state <= adcPkg::idle;
                                end
                        endcase
                end
        end

endmodule

// File: source/readingBank.sv
/*
 * Reading registers for the sweep controller
 * Keeps the latest result of each channel, written from tagged conversion results
 */

`timescale 1ns/1ns

module readingBank (
        input  logic                       clock,
        input  logic                       reset,
        input  adcPkg::conversionResult_t  result,
        output adcPkg::readingArray_t      readings
);

        // one sample register per channel, selected by the result tag
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        readings <= '0;
                end else if (result.valid) begin
                        // a later sweep overwrites the same register
                        readings[result.channel] <= result.value;
                end
        end

endmodule

// File: source/adcSweepTop.sv
/*
 * LTC2308 sweep controller top level
 * Connects the SCLK generator, SPI shifter, sequencer and reading registers
 */

`timescale 1ns/1ns

module adcSweepTop (
        input  logic                   clock,
        input  logic                   reset,
        input  logic                   go,
        input  logic                   dout,
        output logic                   sclk,
        output logic                   cs_n,
        output logic                   din,
        output logic                   done,
        output adcPkg::readingArray_t  readings
);

        logic                       frameActive;
        logic                       loadCommand;
        logic                       risingEdge;
        logic                       fallingEdge;
        logic                       frameEnd;
        logic                       wordReady;
        adcPkg::ltcCommand_t        command;
        adcPkg::sample_t            word;
        adcPkg::conversionResult_t  result;

        // chip-select is also CONVST, so it stays high through every gap
        assign cs_n = !frameActive;

        sclkGenerator sclkGenerator_inst (
                .clock       (clock),
                .reset       (reset),
                .frameActive (frameActive),
                .sclk        (sclk),
                .risingEdge  (risingEdge),
                .fallingEdge (fallingEdge),
                .frameEnd    (frameEnd)
        );

        spiFrameShifter spiFrameShifter_inst (
                .clock       (clock),
                .reset       (reset),
                .loadCommand (loadCommand),
                .command     (command),
                .risingEdge  (risingEdge),
                .fallingEdge (fallingEdge),
                .frameEnd    (frameEnd),
                .dout        (dout),
                .din         (din),
                .word        (word),
                .wordReady   (wordReady)
        );

        // the sequencer steps on the frame end that comes with a complete word
        sweepController sweepController_inst (
                .clock       (clock),
                .reset       (reset),
                .go          (go),
                .frameEnd    (wordReady),
                .word        (word),
                .frameActive (frameActive),
                .loadCommand (loadCommand),
                .command     (command),
                .result      (result),
                .done        (done)
        );

        readingBank readingBank_inst (
                .clock    (clock),
                .reset    (reset),
                .result   (result),
                .readings (readings)
        );

endmodule

// File: sim/ltcModel.sv
/*
 * Behavioral LTC2308 for the sweep testbench
 * Decodes commands, returns the previous conversion and keeps frame statistics
 */

`timescale 1ns/1ns

`include "adc_defs.svh"

module ltcModel (
        input  logic                   clock,
        input  logic                   cs_n,
        input  logic                   sclk,
        input  logic                   din,
        output logic                   dout,
        input  adcPkg::readingArray_t  channelValues
);

        localparam int commandBits = $bits(adcPkg::ltcCommand_t);

        adcPkg::ltcCommand_t commandLog [0:63];
        int                  commandCount = 0;
        int                  frameCount = 0;
        int                  gapsSeen = 0;
        int                  gapMin = 1000000;
        int                  gapMax = 0;
        int                  sclkHighMin = 1000000;
        int                  sclkHighMax = 0;

        logic [commandBits-1:0] commandShift = '0;
        adcPkg::ltcCommand_t    frameCommand = '0;
        adcPkg::sample_t        txWord = '0;
        int                     bitIndex = 0;
        int                     highRun = 0;
        int                     sclkRun = 0;
        logic                   afterFrame = 1'b0;

        // a falling cs_n opens a frame, the command bits follow on rising SCLK
        always @(negedge cs_n or posedge sclk) begin
                if (sclk !== 1'b1) begin
                        frameCount = frameCount + 1;
                        bitIndex   = 0;
                end else begin
                        if (bitIndex < commandBits) begin
                                commandShift = {commandShift[commandBits-2:0], din};
                        end
                        bitIndex = bitIndex + 1;
                        if (bitIndex == commandBits) begin
                                frameCommand = adcPkg::ltcCommand_t'(commandShift);
                                if (commandCount < 64) begin
                                        commandLog[commandCount] = frameCommand;
                                end
                                commandCount = commandCount + 1;
                        end
                end
        end

        // rising cs_n is CONVST, the value comes out MSB first in the next frame
        always @(posedge cs_n or negedge sclk) begin
                if (cs_n === 1'b1) begin
                        txWord = channelValues[{frameCommand.select, frameCommand.oddSign}];
                end else begin
                        txWord = {txWord[`ADC_SAMPLE_BITS-2:0], 1'b0};
                end
        end

        assign dout = txWord[`ADC_SAMPLE_BITS-1];

        // high times are counted in system clocks
        always @(posedge clock) begin
                if (cs_n === 1'b1) begin
                        highRun = highRun + 1;
                end else if (cs_n === 1'b0) begin
                        if (afterFrame && highRun > 0) begin
                                gapsSeen = gapsSeen + 1;
                                if (highRun < gapMin) begin
                                        gapMin = highRun;
                                end
                                if (highRun > gapMax) begin
                                        gapMax = highRun;
                                end
                        end
                        highRun    = 0;
                        afterFrame = 1'b1;
                end
                if (sclk === 1'b1) begin
                        sclkRun = sclkRun + 1;
                end else if (sclkRun > 0) begin
                        if (sclkRun < sclkHighMin) begin
                                sclkHighMin = sclkRun;
                        end
                        if (sclkRun > sclkHighMax) begin
                                sclkHighMax = sclkRun;
                        end
                        sclkRun = 0;
                end
        end

endmodule

// File: sim/adcSweepTb.sv
/*
 * Testbench for the LTC2308 sweep controller
 * Runs directed sweeps against a behavioral ADC and checks readings and timing
 */

`timescale 1ns/1ns

`include "adc_defs.svh"

module adcSweepTb;

        localparam int frameCycles = 2 * `ADC_FRAME_BITS * `ADC_SCLK_HALF;
        localparam int sweepLimit  =
                2 * (`ADC_NUM_CHANNELS + 1) * (frameCycles + `ADC_CONVERSION_CYCLES) + 100;

        logic                  clock;
        logic                  reset;
        logic                  go;
        logic                  sclk;
        logic                  cs_n;
        logic                  din;
        logic                  dout;
        logic                  done;
        adcPkg::readingArray_t readings;
        adcPkg::readingArray_t modelValues;
        adcPkg::sample_t       expected [0:7];
        logic [15:0]           lfsrState;
        int                    errorCount;
        int                    timeoutCount;

        adcSweepTop adcSweepTop_inst (
                .clock    (clock),
                .reset    (reset),
                .go       (go),
                .dout     (dout),
                .sclk     (sclk),
                .cs_n     (cs_n),
                .din      (din),
                .done     (done),
                .readings (readings)
        );

        ltcModel ltcModel_inst (
                .clock         (clock),
                .cs_n          (cs_n),
                .sclk          (sclk),
                .din           (din),
                .dout          (dout),
                .channelValues (modelValues)
        );

        initial begin
                clock = 1'b0;
                forever begin
                        #5 clock = !clock;
                end
        end

        // 16-bit Galois LFSR with taps 16, 14, 13 and 11
        function automatic logic [15:0] galoisStep(input logic [15:0] state);
                logic [15:0] next;
                next = state >> 1;
                if (state[0]) begin
                        next = next ^ 16'hB400;
                end
                return next;
        endfunction

        task automatic drawSample(output adcPkg::sample_t value);
                value = '0;
                for (int i = 0; i < `ADC_SAMPLE_BITS; i++) begin
                        value     = {value[`ADC_SAMPLE_BITS-2:0], lfsrState[0]};
                        lfsrState = galoisStep(lfsrState);
                end
        endtask

        task automatic loadModelValues();
                adcPkg::readingArray_t packedValues;
                adcPkg::sample_t       value;
                for (int ch = 0; ch < 8; ch++) begin
                        drawSample(value);
                        expected[ch]     = value;
                        packedValues[ch] = value;
                end
                @(posedge clock);
                modelValues <= packedValues;
        endtask

        task automatic reportMismatch(input string name, input logic [31:0] actual,
                                      input logic [31:0] wanted);
                errorCount++;
                $display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                         $time, name, actual, wanted);
        endtask

        task automatic waitForDone(input logic level, input int limit, input string label);
                int cycles;
                cycles = 0;
                while (done !== level && cycles < limit) begin
                        @(negedge clock);
                        cycles++;
                end
                if (done !== level) begin
                        timeoutCount++;
                        $display("Timeout: done did not become %0b within %0d cycles in %s",
                                 level, limit, label);
                end
        endtask

        // channels outside the sweep are never written and stay at zero
        task automatic checkReadings();
                adcPkg::sample_t wanted;
                for (int ch = 0; ch < 8; ch++) begin
                        wanted = (ch < `ADC_NUM_CHANNELS) ? expected[ch] : '0;
                        if (readings[ch] !== wanted) begin
                                reportMismatch($sformatf("readings[%0d]", ch), readings[ch], wanted);
                        end
                end
        endtask

        task automatic runSweep(input string label);
                int firstFrame;
                loadModelValues();
                firstFrame = ltcModel_inst.frameCount;
                @(posedge clock);
                go <= 1'b1;
                waitForDone(1'b1, sweepLimit, label);
                checkReadings();
                if (ltcModel_inst.frameCount - firstFrame != `ADC_NUM_CHANNELS + 1) begin
                        reportMismatch("frame count", ltcModel_inst.frameCount - firstFrame,
                                       `ADC_NUM_CHANNELS + 1);
                end
        endtask

        task automatic checkResetState();
                @(negedge clock);
                if (cs_n !== 1'b1) begin
                        reportMismatch("cs_n", cs_n, 1);
                end
                if (sclk !== 1'b0) begin
                        reportMismatch("sclk", sclk, 0);
                end
                if (done !== 1'b0) begin
                        reportMismatch("done", done, 0);
                end
                for (int ch = 0; ch < 8; ch++) begin
                        if (readings[ch] !== '0) begin
                                reportMismatch($sformatf("readings[%0d]", ch), readings[ch], 0);
                        end
                end
        endtask

        // the priming frame asks for channel 0 and frame k asks for channel k, wrapping to 0
        task automatic fullSweep();
                int                  firstCommand;
                adcPkg::ltcCommand_t cmd;
                adcPkg::channel_t    wantedChannel;
                firstCommand = ltcModel_inst.commandCount;
                runSweep("full sweep");
                for (int k = 0; k <= `ADC_NUM_CHANNELS; k++) begin
                        cmd           = ltcModel_inst.commandLog[firstCommand + k];
                        wantedChannel = adcPkg::channel_t'(k % `ADC_NUM_CHANNELS);
                        if ({cmd.select, cmd.oddSign} !== wantedChannel) begin
                                reportMismatch($sformatf("command %0d channel", k),
                                               {cmd.select, cmd.oddSign}, wantedChannel);
                        end
                        if ({cmd.singleEnded, cmd.unipolar, cmd.sleep} !== 3'b110) begin
                                reportMismatch($sformatf("command %0d mode bits", k),
                                               {cmd.singleEnded, cmd.unipolar, cmd.sleep}, 3'b110);
                        end
                end
        endtask

        task automatic goDoneLevels();
                for (int i = 0; i < 20; i++) begin
                        @(negedge clock);
                        if (done !== 1'b1) begin
                                reportMismatch("done while go held", done, 1);
                        end
                end
                @(posedge clock);
                go <= 1'b0;
                waitForDone(1'b0, 2, "go release");
                for (int i = 0; i < 50; i++) begin
                        @(negedge clock);
                        if (cs_n !== 1'b1) begin
                                reportMismatch("cs_n after go release", cs_n, 1);
                        end
                        if (done !== 1'b0) begin
                                reportMismatch("done after go release", done, 0);
                        end
                end
        endtask

        // only gaps inside the first sweep have ended at this point
        task automatic sclkGapTiming();
                if (ltcModel_inst.sclkHighMin != `ADC_SCLK_HALF) begin
                        reportMismatch("shortest sclk high", ltcModel_inst.sclkHighMin,
                                       `ADC_SCLK_HALF);
                end
                if (ltcModel_inst.sclkHighMax != `ADC_SCLK_HALF) begin
                        reportMismatch("longest sclk high", ltcModel_inst.sclkHighMax,
                                       `ADC_SCLK_HALF);
                end
                if (ltcModel_inst.gapsSeen == 0) begin
                        errorCount++;
                        $display("No cs_n gap between two frames was seen");
                end else begin
                        if (ltcModel_inst.gapMin != `ADC_CONVERSION_CYCLES) begin
                                reportMismatch("shortest cs_n gap", ltcModel_inst.gapMin,
                                               `ADC_CONVERSION_CYCLES);
                        end
                        if (ltcModel_inst.gapMax != `ADC_CONVERSION_CYCLES) begin
                                reportMismatch("longest cs_n gap", ltcModel_inst.gapMax,
                                               `ADC_CONVERSION_CYCLES);
                        end
                end
        endtask

        // fresh LFSR values must replace every reading of the first sweep
        task automatic secondSweep();
                runSweep("second sweep");
                @(posedge clock);
                go <= 1'b0;
                waitForDone(1'b0, 2, "second sweep release");
        endtask

        initial begin
                reset        = 1'b1;
                go           = 1'b0;
                modelValues  = '0;
                lfsrState    = 16'd94;
                errorCount   = 0;
                timeoutCount = 0;
                repeat (4) @(posedge clock);
                reset <= 1'b0;
                checkResetState();
                fullSweep();
                goDoneLevels();
                sclkGapTiming();
                secondSweep();
                $display("Summary: %0d errors, %0d timeouts", errorCount, timeoutCount);
                if (errorCount == 0 && timeoutCount == 0) begin
                        $display("All tests passed!");
                end else begin
                        $display("Test failures found");
                end
                $finish;
        end

endmodule

// File: all.f
+incdir+source
source/adcPkg.sv
source/sclkGenerator.sv
source/spiFrameShifter.sv
source/sweepController.sv
source/readingBank.sv
source/adcSweepTop.sv
sim/ltcModel.sv
sim/adcSweepTb.sv

// File: Bender.yml
package:
  name: adc_sweep

sources:
  - include_dirs:
      - source
    files:
      - source/adcPkg.sv
      - source/sclkGenerator.sv
      - source/spiFrameShifter.sv
      - source/sweepController.sv
      - source/readingBank.sv
      - source/adcSweepTop.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/ltcModel.sv
      - sim/adcSweepTb.sv
